//--- Bender.yml
package:
  name: rv_exec

export_include_dirs:
  - include

sources:
  - files:
      - rtl/rv_pkg.sv
      - rtl/rv_decoder.sv
      - rtl/rv_regfile.sv
      - rtl/rv_alu.sv
      - rtl/rv_execute.sv
      - rtl/rv_exec_core.sv
  - target: test
    files:
      - bench/rv_clk_gen.sv
      - bench/rv_exec_properties.sv
      - bench/rv_exec_tb.sv

//--- bench/rv_clk_gen.sv
module rv_clk_gen (
    output logic ex_clk,
    output logic ex_rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        ex_clk = 1'b0;
        forever #4 ex_clk = ~ex_clk;
    end

    // Reset low across the first two rising edges
    initial begin
        ex_rst = 1'b0;
        repeat (2) @(posedge ex_clk);
        #1 ex_rst = 1'b1;
    end

endmodule

//--- bench/rv_exec_cases.txt
// mode instr pc exp_we exp_rd exp_data exp_change_pc exp_next_pc exp_req exp_addr exp_wdata
// mode 0 starts a group, 1 issues right after the previous row, 2 runs alone with a stall
0 00500093 00000100 1 01 00000005 0 00000000 0 00000000 00000000
1 ffd08113 00000104 1 02 00000002 0 00000000 0 00000000 00000000
1 402081b3 00000108 1 03 00000003 0 00000000 0 00000000 00000000
0 00409213 0000010c 1 04 00000050 0 00000000 0 00000000 00000000
0 ff000293 00000110 1 05 fffffff0 0 00000000 0 00000000 00000000
1 4022d313 00000114 1 06 fffffffc 0 00000000 0 00000000 00000000
1 0012a3b3 00000118 1 07 00000001 0 00000000 0 00000000 00000000
1 0012b433 0000011c 1 08 00000000 0 00000000 0 00000000 00000000
1 0042c4b3 00000120 1 09 ffffffa0 0 00000000 0 00000000 00000000
1 0042f8b3 00000124 1 11 00000050 0 00000000 0 00000000 00000000
1 0012d933 00000128 1 12 07ffffff 0 00000000 0 00000000 00000000
0 0ff0e013 0000012c 0 00 00000000 0 00000000 0 00000000 00000000
0 12345537 00000130 1 0a 12345000 0 00000000 0 00000000 00000000
0 00001597 00000400 1 0b 00001400 0 00000000 0 00000000 00000000
0 00108863 00000200 0 00 00000000 1 00000210 0 00000000 00000000
1 00700613 00000204 0 00 00000000 0 00000000 0 00000000 00000000
0 001606b3 00000208 1 0d 00000005 0 00000000 0 00000000 00000000
0 00109863 00000240 0 00 00000000 0 00000000 0 00000000 00000000
0 fe12cce3 00000300 0 00 00000000 1 000002f8 0 00000000 00000000
0 0050f463 00000320 0 00 00000000 0 00000000 0 00000000 00000000
0 0012f463 00000340 0 00 00000000 1 00000348 0 00000000 00000000
0 0200076f 00000400 1 0e 00000404 1 00000420 0 00000000 00000000
0 004087e7 00000500 1 0f 00000504 1 00000008 0 00000000 00000000
2 0040a423 00000600 0 00 00000000 0 00000000 1 0000000d 00000050
2 ffc52803 00000604 0 00 00000000 0 00000000 1 12344ffc 00000000

//--- bench/rv_exec_properties.sv
module rv_exec_properties import rv_pkg::*; (
    input logic     ex_clk,
    input logic     ex_rst,
    input logic     stall,
    input wb_t      wb,
    input mem_req_t mem_req,
    input logic     change_pc
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // Redirect is a single-cycle pulse
    assert property (@(posedge ex_clk) disable iff (!ex_rst)
        change_pc |=> !change_pc)
        else begin
            fail_count++;
            $error("change_pc high in two consecutive cycles");
        end

    assert property (@(posedge ex_clk) disable iff (!ex_rst)
        wb.we |-> (wb.rd != '0))
        else begin
            fail_count++;
            $error("wb.we raised for a write to x0");
        end

    // Strobes registered under stall come out low
    assert property (@(posedge ex_clk) disable iff (!ex_rst)
        stall |=> !(wb.we || mem_req.req || change_pc))
        else begin
            fail_count++;
            $error("output strobe high after a stalled cycle");
        end

    assert property (@(posedge ex_clk) disable iff (!ex_rst)
        !(mem_req.req && wb.we))
        else begin
            fail_count++;
            $error("mem_req.req and wb.we high together");
        end

endmodule

//--- bench/rv_exec_tb.sv
module rv_exec_tb import rv_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int COLS      = 11;
    localparam int MAX_CASES = 64;
    localparam int TIMEOUT   = 20;

    // Column positions in a case row
    localparam int C_MODE  = 0;
    localparam int C_INSTR = 1;
    localparam int C_PC    = 2;
    localparam int C_WE    = 3;
    localparam int C_RD    = 4;
    localparam int C_DATA  = 5;
    localparam int C_CHG   = 6;
    localparam int C_NPC   = 7;
    localparam int C_REQ   = 8;
    localparam int C_ADDR  = 9;
    localparam int C_WDATA = 10;

    logic     ex_clk;
    logic     ex_rst;
    xlen_t    instr;
    pc_t      pc;
    logic     ce;
    logic     stall;
    logic     flush;
    wb_t      wb;
    mem_req_t mem_req;
    logic     change_pc;
    pc_t      next_pc;

    xlen_t cases [MAX_CASES*COLS];
    int    num_cases;
    int    case_errs;
    int    passed;
    int    failed;

    rv_clk_gen u_clk_gen (
        .ex_clk (ex_clk),
        .ex_rst (ex_rst)
    );

    rv_exec_core uut (
        .ex_clk    (ex_clk),
        .ex_rst    (ex_rst),
        .instr     (instr),
        .pc        (pc),
        .ce        (ce),
        .stall     (stall),
        .flush     (flush),
        .wb        (wb),
        .mem_req   (mem_req),
        .change_pc (change_pc),
        .next_pc   (next_pc)
    );

    bind rv_execute rv_exec_properties u_properties (
        .ex_clk    (ex_clk),
        .ex_rst    (ex_rst),
        .stall     (stall),
        .wb        (wb),
        .mem_req   (mem_req),
        .change_pc (change_pc)
    );

    function automatic xlen_t case_field(int idx, int col);
        return cases[idx*COLS + col];
    endfunction

    task automatic report_value(string name, xlen_t got, xlen_t exp);
        $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
        case_errs++;
    endtask

    task automatic drive_instr(int idx);
        instr = case_field(idx, C_INSTR);
        pc    = case_field(idx, C_PC);
        ce    = 1'b1;
    endtask

    task automatic drive_idle();
        instr = '0;
        pc    = '0;
        ce    = 1'b0;
    endtask

    task automatic check_result(int idx);
        xlen_t word;
        logic  is_store;
        word      = case_field(idx, C_INSTR);
        is_store  = (word[6:0] == 7'b0100011);
        case_errs = 0;
        if (xlen_t'(wb.we) !== case_field(idx, C_WE)) begin
            report_value("wb.we", xlen_t'(wb.we), case_field(idx, C_WE));
        end
        if (case_field(idx, C_WE) == 1 && xlen_t'(wb.rd) !== case_field(idx, C_RD)) begin
            report_value("wb.rd", xlen_t'(wb.rd), case_field(idx, C_RD));
        end
        if (case_field(idx, C_WE) == 1 && wb.data !== case_field(idx, C_DATA)) begin
            report_value("wb.data", wb.data, case_field(idx, C_DATA));
        end
        if (xlen_t'(change_pc) !== case_field(idx, C_CHG)) begin
            report_value("change_pc", xlen_t'(change_pc), case_field(idx, C_CHG));
        end
        if (case_field(idx, C_CHG) == 1 && next_pc !== case_field(idx, C_NPC)) begin
            report_value("next_pc", next_pc, case_field(idx, C_NPC));
        end
        if (xlen_t'(mem_req.req) !== case_field(idx, C_REQ)) begin
            report_value("mem_req.req", xlen_t'(mem_req.req), case_field(idx, C_REQ));
        end
        if (case_field(idx, C_REQ) == 1 && mem_req.addr !== case_field(idx, C_ADDR)) begin
            report_value("mem_req.addr", mem_req.addr, case_field(idx, C_ADDR));
        end
        if (case_field(idx, C_REQ) == 1 && mem_req.store !== is_store) begin
            report_value("mem_req.store", xlen_t'(mem_req.store), xlen_t'(is_store));
        end
        if (is_store && mem_req.wdata !== case_field(idx, C_WDATA)) begin
            report_value("mem_req.wdata", mem_req.wdata, case_field(idx, C_WDATA));
        end
        if (case_errs == 0) begin
            passed++;
            $display("case %0d instr %h ok", idx, word);
        end else begin
            failed++;
            $display("case %0d instr %h failed with %0d errors", idx, word, case_errs);
        end
    endtask

    // Results land two edges after issue
    task automatic run_group(int first, int count);
        for (int k = 0; k < count + 2; k++) begin
            if (k < count) begin
                drive_instr(first + k);
            end else begin
                drive_idle();
            end
            @(negedge ex_clk);
            if (k >= 2) begin
                check_result(first + k - 2);
            end
            @(posedge ex_clk);
            #1;
        end
    endtask

    task automatic run_stalled(int idx);
        int gap;
        int waited;
        drive_instr(idx);
        @(posedge ex_clk);
        #1;
        drive_idle();
        gap   = 1 + ($urandom % 4);
        stall = 1'b1;
        repeat (gap) begin
            @(posedge ex_clk);
            #1;
        end
        stall  = 1'b0;
        waited = 0;
        @(negedge ex_clk);
        while (!(wb.we || mem_req.req || change_pc) && waited < TIMEOUT) begin
            @(negedge ex_clk);
            waited++;
        end
        if (waited >= TIMEOUT) begin
            failed++;
            $display("case %0d timed out waiting for an output strobe", idx);
        end else begin
            check_result(idx);
        end
        @(posedge ex_clk);
        #1;
    endtask

    initial begin
        int guard;
        int idx;
        int count;
        int assert_fails;
        void'($urandom(32'h4e1d_9e22));
        instr  = '0;
        pc     = '0;
        ce     = 1'b0;
        stall  = 1'b0;
        flush  = 1'b0;
        passed = 0;
        failed = 0;
        $readmemh("bench/rv_exec_cases.txt", cases);
        num_cases = 0;
        while (num_cases < MAX_CASES && !$isunknown(cases[num_cases*COLS + C_INSTR])) begin
            num_cases++;
        end
        guard = 0;
        while (ex_rst !== 1'b1 && guard < TIMEOUT) begin
            @(posedge ex_clk);
            guard++;
        end
        if (ex_rst !== 1'b1) begin
            $display("reset was never released");
            $display("Test failed");
            $finish;
        end else begin
            @(posedge ex_clk);
            #1;
            idx = 0;
            while (idx < num_cases) begin
                if (case_field(idx, C_MODE) == 2) begin
                    run_stalled(idx);
                    idx++;
                end else begin
                    count = 1;
                    while (idx + count < num_cases && case_field(idx + count, C_MODE) == 1) begin
                        count++;
                    end
                    run_group(idx, count);
                    idx += count;
                end
            end
            if (num_cases == 0) begin
                failed++;
                $display("no cases could be read from bench/rv_exec_cases.txt");
            end
            assert_fails = uut.u_execute.u_properties.fail_count;
            $display("%0d cases run, %0d passed, %0d failed, %0d assertion failures",
                     num_cases, passed, failed, assert_fails);
            if (failed == 0 && assert_fails == 0) begin
                $display("Test passed");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

endmodule

//--- include/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

`define XLEN          32
`define AWIDTH        5
`define FUNCT_WIDTH   3
`define ALU_WIDTH     14
`define OPCODE_WIDTH  11

// One-hot ALU bit positions
`define ADD   0
`define SUB   1
`define SLT   2
`define SLTU  3
`define XOR   4
`define OR    5
`define AND   6
`define SLL   7
`define SRL   8
`define SRA   9
`define EQ    10
`define NEQ   11
`define GE    12
`define GEU   13

// One-hot opcode class positions
`define RTYPE       0
`define ITYPE       1
`define LOAD_WORD   2
`define STORE_WORD  3
`define BRANCH      4
`define JAL         5
`define JALR        6
`define LUI         7
`define AUIPC       8
`define SYSTEM      9
`define FENCE       10

// RV32 major opcodes
`define OPC_RTYPE   7'b0110011
`define OPC_ITYPE   7'b0010011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_SYSTEM  7'b1110011
`define OPC_FENCE   7'b0001111

`endif

//--- rtl/rv_alu.sv
`include "rv_defs.svh"

module rv_alu import rv_pkg::*; (
    input  decoded_t dec,
    input  xlen_t    rs1_value,
    input  xlen_t    rs2_value,
    output xlen_t    alu_value
);

    xlen_t      a;
    xlen_t      b;
    logic [4:0] shamt;

    // Operand A is PC for JAL and AUIPC, zero for LUI
    always_comb begin
        if (dec.opcode[`JAL] || dec.opcode[`AUIPC]) begin
            a = dec.pc;
        end else if (dec.opcode[`LUI]) begin
            a = '0;
        end else begin
            a = rs1_value;
        end
    end

    assign b = (dec.opcode[`RTYPE] || dec.opcode[`BRANCH]) ? rs2_value : dec.imm;
    assign shamt = b[4:0];

    always_comb begin
        case (1'b1)
            dec.alu[`ADD]:  alu_value = a + b;
            dec.alu[`SUB]:  alu_value = a - b;
            dec.alu[`SLT]:  alu_value = xlen_t'($signed(a) < $signed(b));
            dec.alu[`SLTU]: alu_value = xlen_t'(a < b);
            dec.alu[`XOR]:  alu_value = a ^ b;
            dec.alu[`OR]:   alu_value = a | b;
            dec.alu[`AND]:  alu_value = a & b;
            dec.alu[`SLL]:  alu_value = a << shamt;
            dec.alu[`SRL]:  alu_value = a >> shamt;
            dec.alu[`SRA]:  alu_value = xlen_t'($signed(a) >>> shamt);
            dec.alu[`EQ]:   alu_value = xlen_t'(a == b);
            dec.alu[`NEQ]:  alu_value = xlen_t'(a != b);
            dec.alu[`GE]:   alu_value = xlen_t'($signed(a) >= $signed(b));
            dec.alu[`GEU]:  alu_value = xlen_t'(a >= b);
            default:        alu_value = '0;
        endcase
    end

endmodule

//--- rtl/rv_decoder.sv
`include "rv_defs.svh"

module rv_decoder import rv_pkg::*; (
    input  logic     ex_clk,
    input  logic     ex_rst,
    input  xlen_t    instr,
    input  pc_t      pc,
    input  logic     ce,
    input  logic     stall,
    input  logic     flush,
    input  logic     kill,
    output decoded_t dec
);

    funct3_t  funct3;
    alu_op_t  alu_d;
    opcode_t  opc_d;
    xlen_t    imm_d;
    decoded_t dec_d;

    // R-type and I-type share the funct3 map, alt picks SUB or SRA
    function automatic alu_op_t arith_op(funct3_t f3, logic alt);
        alu_op_t op;
        op = '0;
        case (f3)
            3'b000: op[alt ? `SUB : `ADD] = 1'b1;
            3'b001: op[`SLL] = 1'b1;
            3'b010: op[`SLT] = 1'b1;
            3'b011: op[`SLTU] = 1'b1;
            3'b100: op[`XOR] = 1'b1;
            3'b101: op[alt ? `SRA : `SRL] = 1'b1;
            3'b110: op[`OR] = 1'b1;
            default: op[`AND] = 1'b1;
        endcase
        return op;
    endfunction

    assign funct3 = instr[14:12];

    always_comb begin
        alu_d = '0;
        opc_d = '0;
        imm_d = '0;
        case (instr[6:0])
            `OPC_RTYPE: begin
                opc_d[`RTYPE] = 1'b1;
                alu_d = arith_op(funct3, instr[30]);
            end
            `OPC_ITYPE: begin
                opc_d[`ITYPE] = 1'b1;
                // No SUBI, so funct7 only matters for right shifts
                alu_d = arith_op(funct3, instr[30] && (funct3 == 3'b101));
                imm_d = {{20{instr[31]}}, instr[31:20]};
            end
            `OPC_LOAD, `OPC_JALR: begin
                opc_d[(instr[6:0] == `OPC_LOAD) ? `LOAD_WORD : `JALR] = 1'b1;
                alu_d[`ADD] = 1'b1;
                imm_d = {{20{instr[31]}}, instr[31:20]};
            end
            `OPC_STORE: begin
                opc_d[`STORE_WORD] = 1'b1;
                alu_d[`ADD] = 1'b1;
                imm_d = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            `OPC_BRANCH: begin
                opc_d[`BRANCH] = 1'b1;
                case (funct3)
                    3'b000: alu_d[`EQ] = 1'b1;
                    3'b001: alu_d[`NEQ] = 1'b1;
                    3'b100: alu_d[`SLT] = 1'b1;
                    3'b101: alu_d[`GE] = 1'b1;
                    3'b110: alu_d[`SLTU] = 1'b1;
                    default: alu_d[`GEU] = 1'b1;
                endcase
                imm_d = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                         instr[11:8], 1'b0};
            end
            `OPC_JAL: begin
                opc_d[`JAL] = 1'b1;
                alu_d[`ADD] = 1'b1;
                imm_d = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                         instr[30:21], 1'b0};
            end
            `OPC_LUI, `OPC_AUIPC: begin
                opc_d[(instr[6:0] == `OPC_LUI) ? `LUI : `AUIPC] = 1'b1;
                alu_d[`ADD] = 1'b1;
                imm_d = {instr[31:12], 12'b0};
            end
            `OPC_SYSTEM: opc_d[`SYSTEM] = 1'b1;
            `OPC_FENCE:  opc_d[`FENCE] = 1'b1;
            default: ;
        endcase
    end

    assign dec_d = '{valid: 1'b1, pc: pc, alu: alu_d, opcode: opc_d, funct3: funct3,
                     rs1: instr[19:15], rs2: instr[24:20], rd: instr[11:7], imm: imm_d};

    always_ff @(posedge ex_clk or negedge ex_rst) begin
        if (!ex_rst) begin
            dec <= '0;
        end else if (flush || kill) begin
            dec.valid <= 1'b0;
        end else if (!stall) begin
            if (ce) begin
                dec <= dec_d;
            end else begin
                dec.valid <= 1'b0;
            end
        end
    end

endmodule

//--- rtl/rv_exec_core.sv
module rv_exec_core import rv_pkg::*; (
    input  logic     ex_clk,
    input  logic     ex_rst,
    input  xlen_t    instr,
    input  pc_t      pc,
    input  logic     ce,
    input  logic     stall,
    input  logic     flush,
    output wb_t      wb,
    output mem_req_t mem_req,
    output logic     change_pc,
    output pc_t      next_pc
);

    decoded_t dec;
    xlen_t    rs1_data, rs2_data;
    xlen_t    rs1_value, rs2_value;
    xlen_t    alu_value;

    // change_pc doubles as the decode kill
    rv_decoder u_decoder (
        .ex_clk (ex_clk),
        .ex_rst (ex_rst),
        .instr  (instr),
        .pc     (pc),
        .ce     (ce),
        .stall  (stall),
        .flush  (flush),
        .kill   (change_pc),
        .dec    (dec)
    );

    rv_regfile u_regfile (
        .ex_clk   (ex_clk),
        .ex_rst   (ex_rst),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

    rv_alu u_alu (
        .dec       (dec),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .alu_value (alu_value)
    );

    rv_execute u_execute (
        .ex_clk    (ex_clk),
        .ex_rst    (ex_rst),
        .dec       (dec),
        .stall     (stall),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .alu_value (alu_value),
        .wb        (wb),
        .mem_req   (mem_req),
        .change_pc (change_pc),
        .next_pc   (next_pc)
    );

endmodule

//--- rtl/rv_execute.sv
`include "rv_defs.svh"

module rv_execute import rv_pkg::*; (
    input  logic     ex_clk,
    input  logic     ex_rst,
    input  decoded_t dec,
    input  logic     stall,
    input  xlen_t    rs1_data,
    input  xlen_t    rs2_data,
    output xlen_t    rs1_value,
    output xlen_t    rs2_value,
    input  xlen_t    alu_value,
    output wb_t      wb,
    output mem_req_t mem_req,
    output logic     change_pc,
    output pc_t      next_pc
);

    logic      wb_we_q, req_q, change_pc_q;
    logic      store_q;
    reg_addr_t wb_rd_q;
    xlen_t     wb_data_q, addr_q, wdata_q;
    pc_t       next_pc_q;

    logic  op_rtype, op_itype, op_load, op_store, op_branch;
    logic  op_jal, op_jalr, op_lui, op_auipc;
    logic  issue, writes_rd, taken;
    pc_t   pc_plus4, target;
    xlen_t rd_value;

    assign op_rtype  = dec.opcode[`RTYPE];
    assign op_itype  = dec.opcode[`ITYPE];
    assign op_load   = dec.opcode[`LOAD_WORD];
    assign op_store  = dec.opcode[`STORE_WORD];
    assign op_branch = dec.opcode[`BRANCH];
    assign op_jal    = dec.opcode[`JAL];
    assign op_jalr   = dec.opcode[`JALR];
    assign op_lui    = dec.opcode[`LUI];
    assign op_auipc  = dec.opcode[`AUIPC];

    // Last result bypasses the register file write that lands this edge
    assign rs1_value = (wb_we_q && (wb_rd_q != '0) && (wb_rd_q == dec.rs1)) ? wb_data_q
                                                                             : rs1_data;
    assign rs2_value = (wb_we_q && (wb_rd_q != '0) && (wb_rd_q == dec.rs2)) ? wb_data_q
                                                                             : rs2_data;

    // Younger instruction in decode is squashed while change_pc is high
    assign issue     = dec.valid && !stall && !change_pc_q;
    assign writes_rd = op_rtype || op_itype || op_lui || op_auipc || op_jal || op_jalr;
    // Bit 0 of the ALU result holds the branch compare
    assign taken     = (op_branch && alu_value[0]) || op_jal || op_jalr;
    assign pc_plus4  = dec.pc + 32'd4;

    // LUI and AUIPC results come straight from the ALU
    always_comb begin
        if (op_jal || op_jalr) begin
            rd_value = pc_plus4;
        end else begin
            rd_value = alu_value;
        end
    end

    always_comb begin
        if (op_branch) begin
            target = alu_value[0] ? dec.pc + dec.imm : pc_plus4;
        end else if (op_jal) begin
            target = alu_value;
        end else if (op_jalr) begin
            target = {alu_value[31:1], 1'b0};
        end else begin
            target = pc_plus4;
        end
    end

    always_ff @(posedge ex_clk or negedge ex_rst) begin
        if (!ex_rst) begin
            wb_we_q     <= 1'b0;
            req_q       <= 1'b0;
            change_pc_q <= 1'b0;
        end else begin
            wb_we_q     <= issue && writes_rd && (dec.rd != '0);
            req_q       <= issue && (op_load || op_store);
            change_pc_q <= issue && taken;
        end
    end

    always_ff @(posedge ex_clk) begin
        if (issue) begin
            wb_rd_q   <= dec.rd;
            wb_data_q <= rd_value;
            store_q   <= op_store;
            addr_q    <= alu_value;
            wdata_q   <= rs2_value;
            next_pc_q <= target;
        end
    end

    assign wb        = '{we: wb_we_q, rd: wb_rd_q, data: wb_data_q};
    assign mem_req   = '{req: req_q, store: store_q, addr: addr_q, wdata: wdata_q};
    assign change_pc = change_pc_q;
    assign next_pc   = next_pc_q;

endmodule

//--- rtl/rv_pkg.sv
`include "rv_defs.svh"

package rv_pkg;

    typedef logic [`XLEN-1:0]         xlen_t;
    typedef logic [`XLEN-1:0]         pc_t;
    typedef logic [`AWIDTH-1:0]       reg_addr_t;
    typedef logic [`FUNCT_WIDTH-1:0]  funct3_t;
    typedef logic [`ALU_WIDTH-1:0]    alu_op_t;
    typedef logic [`OPCODE_WIDTH-1:0] opcode_t;

    // Decode stage to execute stage
    typedef struct packed {
        logic      valid;
        pc_t       pc;
        alu_op_t   alu;
        opcode_t   opcode;
        funct3_t   funct3;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        xlen_t     imm;
    } decoded_t;

    // Register writeback
    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        xlen_t     data;
    } wb_t;

    // Load and store request, one-cycle strobe
    typedef struct packed {
        logic  req;
        logic  store;
        xlen_t addr;
        xlen_t wdata;
    } mem_req_t;

endpackage

//--- rtl/rv_regfile.sv
`include "rv_defs.svh"

module rv_regfile import rv_pkg::*; (
    input  logic      ex_clk,
    input  logic      ex_rst,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    output xlen_t     rs1_data,
    output xlen_t     rs2_data,
    input  wb_t       wb
);

    xlen_t regs [(1 << `AWIDTH)];

    // Entry 0 is never written, so x0 stays zero after reset
    always_ff @(posedge ex_clk or negedge ex_rst) begin
        if (!ex_rst) begin
            for (int i = 0; i < (1 << `AWIDTH); i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule

//--- src.f
+incdir+include
rtl/rv_pkg.sv
rtl/rv_decoder.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_execute.sv
rtl/rv_exec_core.sv
bench/rv_clk_gen.sv
bench/rv_exec_properties.sv
bench/rv_exec_tb.sv
